//--- Makefile
VERILATOR ?= verilator
TOP       := tb_csr_trap
FILELIST  := sim.f
VFLAGS    := --binary --timing --timescale 1ns/1ps
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/csr_decode.sv
`timescale 1ns/1ps

module csr_decode (
    input  rv_isa_pkg::instr_t    instr_i,
    output rv_isa_pkg::csr_op_e   csr_op_o,
    output rv_isa_pkg::csr_addr_t csr_addr_o,
    output logic                  use_imm_o,
    output rv_isa_pkg::xlen_t     imm_o,
    output logic                  csr_wen_o,
    output logic                  is_ecall_o,
    output logic                  is_mret_o
);

    logic       is_system;
    logic [2:0] funct3;
    logic [4:0] rs1_field;
    logic       set_or_clear;

    assign is_system = (instr_i[6:0] == rv_isa_pkg::OPC_SYSTEM);
    assign funct3    = instr_i[14:12];
    assign rs1_field = instr_i[19:15];

    assign csr_addr_o = instr_i[31:20];
    // uimm for the i-forms, zero extended
    assign imm_o      = {59'd0, rs1_field};

    always_comb begin
        csr_op_o   = rv_isa_pkg::CSR_NONE;
        use_imm_o  = 1'b0;
        is_ecall_o = 1'b0;
        is_mret_o  = 1'b0;
        if (is_system) begin
            case (funct3)
                rv_isa_pkg::F3_CSRRW:  csr_op_o = rv_isa_pkg::CSR_WRITE;
                rv_isa_pkg::F3_CSRRS:  csr_op_o = rv_isa_pkg::CSR_SET;
                rv_isa_pkg::F3_CSRRC:  csr_op_o = rv_isa_pkg::CSR_CLEAR;
                rv_isa_pkg::F3_CSRRWI: begin
                    csr_op_o  = rv_isa_pkg::CSR_WRITE;
                    use_imm_o = 1'b1;
                end
                rv_isa_pkg::F3_CSRRSI: begin
                    csr_op_o  = rv_isa_pkg::CSR_SET;
                    use_imm_o = 1'b1;
                end
                rv_isa_pkg::F3_CSRRCI: begin
                    csr_op_o  = rv_isa_pkg::CSR_CLEAR;
                    use_imm_o = 1'b1;
                end
                rv_isa_pkg::F3_PRIV: begin
                    is_ecall_o = (instr_i[31:20] == rv_isa_pkg::FUNCT12_ECALL);
                    is_mret_o  = (instr_i[31:20] == rv_isa_pkg::FUNCT12_MRET);
                end
                default: ;
            endcase
        end
    end

    // set/clear with x0 or uimm 0 only reads
    assign set_or_clear = (csr_op_o == rv_isa_pkg::CSR_SET) ||
                          (csr_op_o == rv_isa_pkg::CSR_CLEAR);
    assign csr_wen_o    = (csr_op_o == rv_isa_pkg::CSR_WRITE) ||
                          (set_or_clear && (rs1_field != 5'd0));

endmodule

//--- rtl/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid_i,
    input  rv_isa_pkg::xlen_t     pc_i,
    input  rv_isa_pkg::csr_op_e   csr_op_i,
    input  rv_isa_pkg::csr_addr_t csr_addr_i,
    input  logic                  csr_wen_i,
    input  logic                  use_imm_i,
    input  rv_isa_pkg::xlen_t     imm_i,
    input  rv_isa_pkg::xlen_t     rs1_data_i,
    input  logic                  is_ecall_i,
    input  logic                  is_mret_i,
    input  logic                  timer_pending_i,
    output rv_isa_pkg::xlen_t     csr_rdata_o,
    output logic                  redirect_o,
    output rv_isa_pkg::xlen_t     redirect_pc_o
);

    // only mie/mpie of mstatus and mtie of mie are stored
    logic              mstatus_mie_q;
    logic              mstatus_mpie_q;
    logic              mie_mtie_q;
    rv_isa_pkg::xlen_t mtvec_q;
    rv_isa_pkg::xlen_t mepc_q;
    rv_isa_pkg::xlen_t mcause_q;

    rv_isa_pkg::xlen_t mstatus_rd;
    rv_isa_pkg::xlen_t mie_rd;
    rv_isa_pkg::xlen_t mip_rd;
    rv_isa_pkg::xlen_t csr_old;
    rv_isa_pkg::xlen_t operand;
    rv_isa_pkg::xlen_t csr_wval;
    rv_isa_pkg::xlen_t trap_cause;

    logic take_intr;
    logic take_ecall;
    logic take_trap;
    logic take_mret;
    logic csr_exec;
    logic csr_we;

    // interrupt wins over whatever instruction is presented
    assign take_intr  = instr_valid_i && timer_pending_i && mie_mtie_q && mstatus_mie_q;
    assign take_ecall = instr_valid_i && is_ecall_i && !take_intr;
    assign take_mret  = instr_valid_i && is_mret_i && !take_intr;
    assign take_trap  = take_intr || take_ecall;
    assign trap_cause = take_intr ? trap_pkg::CAUSE_M_TIMER_INT : trap_pkg::CAUSE_ECALL_M;

    assign csr_exec = instr_valid_i && !take_intr && (csr_op_i != rv_isa_pkg::CSR_NONE);
    assign csr_we   = instr_valid_i && !take_intr && csr_wen_i;

    // read views with the fixed fields filled in
    always_comb begin
        mstatus_rd = trap_pkg::MSTATUS_RESET;
        mstatus_rd[trap_pkg::MSTATUS_MIE_BIT]  = mstatus_mie_q;
        mstatus_rd[trap_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie_q;
        mie_rd = '0;
        mie_rd[trap_pkg::MIE_MTIE_BIT] = mie_mtie_q;
        mip_rd = '0;
        mip_rd[trap_pkg::MIP_MTIP_BIT] = timer_pending_i;
    end

    always_comb begin
        case (csr_addr_i)
            rv_isa_pkg::CSR_MSTATUS: csr_old = mstatus_rd;
            rv_isa_pkg::CSR_MIE:     csr_old = mie_rd;
            rv_isa_pkg::CSR_MTVEC:   csr_old = mtvec_q;
            rv_isa_pkg::CSR_MEPC:    csr_old = mepc_q;
            rv_isa_pkg::CSR_MCAUSE:  csr_old = mcause_q;
            rv_isa_pkg::CSR_MIP:     csr_old = mip_rd;
            default:                 csr_old = '0;
        endcase
    end

    assign csr_rdata_o = csr_exec ? csr_old : '0;

    assign operand = use_imm_i ? imm_i : rs1_data_i;

    always_comb begin
        case (csr_op_i)
            rv_isa_pkg::CSR_WRITE: csr_wval = operand;
            rv_isa_pkg::CSR_SET:   csr_wval = csr_old | operand;
            rv_isa_pkg::CSR_CLEAR: csr_wval = csr_old & ~operand;
            default:               csr_wval = csr_old;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
        end else if (take_trap) begin
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
        end else if (take_mret) begin
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
        end else if (csr_we && csr_addr_i == rv_isa_pkg::CSR_MSTATUS) begin
            mstatus_mie_q  <= csr_wval[trap_pkg::MSTATUS_MIE_BIT];
            mstatus_mpie_q <= csr_wval[trap_pkg::MSTATUS_MPIE_BIT];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_mtie_q <= 1'b0;
            mtvec_q    <= '0;
        end else if (csr_we) begin
            if (csr_addr_i == rv_isa_pkg::CSR_MIE) begin
                mie_mtie_q <= csr_wval[trap_pkg::MIE_MTIE_BIT];
            end
            if (csr_addr_i == rv_isa_pkg::CSR_MTVEC) begin
                mtvec_q <= csr_wval & trap_pkg::PC_ALIGN_MASK;
            end
        end
    end

    // trap entry overrides a software write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q   <= '0;
            mcause_q <= '0;
        end else if (take_trap) begin
            mepc_q   <= pc_i & trap_pkg::PC_ALIGN_MASK;
            mcause_q <= trap_cause;
        end else if (csr_we) begin
            if (csr_addr_i == rv_isa_pkg::CSR_MEPC) begin
                mepc_q <= csr_wval & trap_pkg::PC_ALIGN_MASK;
            end
            if (csr_addr_i == rv_isa_pkg::CSR_MCAUSE) begin
                mcause_q <= csr_wval;
            end
        end
    end

    assign redirect_o    = take_trap || take_mret;
    assign redirect_pc_o = take_trap ? mtvec_q : (take_mret ? mepc_q : '0);

endmodule

//--- rtl/csr_trap_top.sv
`timescale 1ns/1ps

module csr_trap_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid_i,
    input  rv_isa_pkg::instr_t instr_i,
    input  rv_isa_pkg::xlen_t pc_i,
    input  rv_isa_pkg::xlen_t csr_rs1_data_i,
    input  logic              tcmp_we_i,
    input  rv_isa_pkg::xlen_t tcmp_wdata_i,
    output rv_isa_pkg::xlen_t csr_rdata_o,
    output logic              redirect_o,
    output rv_isa_pkg::xlen_t redirect_pc_o
);

    rv_isa_pkg::csr_op_e   csr_op;
    rv_isa_pkg::csr_addr_t csr_addr;
    rv_isa_pkg::xlen_t     csr_imm;
    logic                  use_imm;
    logic                  csr_wen;
    logic                  is_ecall;
    logic                  is_mret;
    logic                  timer_pending;

    csr_decode u_decode (
        .instr_i    (instr_i),
        .csr_op_o   (csr_op),
        .csr_addr_o (csr_addr),
        .use_imm_o  (use_imm),
        .imm_o      (csr_imm),
        .csr_wen_o  (csr_wen),
        .is_ecall_o (is_ecall),
        .is_mret_o  (is_mret)
    );

    csr_file u_csr_file (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr_valid_i   (instr_valid_i),
        .pc_i            (pc_i),
        .csr_op_i        (csr_op),
        .csr_addr_i      (csr_addr),
        .csr_wen_i       (csr_wen),
        .use_imm_i       (use_imm),
        .imm_i           (csr_imm),
        .rs1_data_i      (csr_rs1_data_i),
        .is_ecall_i      (is_ecall),
        .is_mret_i       (is_mret),
        .timer_pending_i (timer_pending),
        .csr_rdata_o     (csr_rdata_o),
        .redirect_o      (redirect_o),
        .redirect_pc_o   (redirect_pc_o)
    );

    machine_timer u_timer (
        .clk             (clk),
        .rst_n           (rst_n),
        .tcmp_we_i       (tcmp_we_i),
        .tcmp_wdata_i    (tcmp_wdata_i),
        .timer_pending_o (timer_pending)
    );

endmodule

//--- rtl/machine_timer.sv
`timescale 1ns/1ps

module machine_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tcmp_we_i,
    input  rv_isa_pkg::xlen_t tcmp_wdata_i,
    output logic              timer_pending_o
);

    rv_isa_pkg::xlen_t mtime_q;
    rv_isa_pkg::xlen_t mtimecmp_q;

    // free running, wraps at 2^64
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // all ones keeps the interrupt quiet until software arms it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_q <= '1;
        end else if (tcmp_we_i) begin
            mtimecmp_q <= tcmp_wdata_i;
        end
    end

    // level, registered so a new compare value shows one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_pending_o <= 1'b0;
        end else begin
            timer_pending_o <= (mtime_q >= mtimecmp_q);
        end
    end

endmodule

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    // machine word, instruction word and csr address
    typedef logic [63:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [11:0] csr_addr_t;

    // major opcode of the SYSTEM group
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 of the zicsr instructions
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    // ecall and mret share funct3 and differ in the upper 12 bits
    localparam logic [2:0]  F3_PRIV       = 3'b000;
    localparam logic [11:0] FUNCT12_ECALL = 12'h000;
    localparam logic [11:0] FUNCT12_MRET  = 12'h302;

    // machine csr addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MIE     = 12'h304;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;
    localparam csr_addr_t CSR_MIP     = 12'h344;

    // kind of read-modify-write
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

endpackage

//--- rtl/trap_pkg.sv
package trap_pkg;

    // mcause values
    localparam logic [63:0] CAUSE_ECALL_M     = 64'd11;
    localparam logic [63:0] CAUSE_M_TIMER_INT = 64'h8000_0000_0000_0007;

    // bit positions inside mstatus, mie and mip
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MTIE_BIT     = 7;
    localparam int MIP_MTIP_BIT     = 7;

    // uxl, sxl and mpp fixed for an m-only 64-bit hart
    localparam logic [63:0] MSTATUS_RESET = 64'h0000_000a_0000_1800;

    // trap vector and return pc are word aligned
    localparam logic [63:0] PC_ALIGN_MASK = ~64'd3;

endpackage

//--- sim.f
rtl/rv_isa_pkg.sv
rtl/trap_pkg.sv
rtl/csr_decode.sv
rtl/csr_file.sv
rtl/machine_timer.sv
rtl/csr_trap_top.sv
testbench/tb_csr_trap.sv

//--- testbench/tb_csr_trap.sv
`timescale 1ns/1ps

module tb_csr_trap;

    typedef enum logic [1:0] {ROW_INSTR, ROW_TCMP, ROW_IDLE} row_kind_e;

    localparam rv_isa_pkg::csr_addr_t A_MSTATUS = rv_isa_pkg::CSR_MSTATUS;
    localparam rv_isa_pkg::csr_addr_t A_MIE     = rv_isa_pkg::CSR_MIE;
    localparam rv_isa_pkg::csr_addr_t A_MTVEC   = rv_isa_pkg::CSR_MTVEC;
    localparam rv_isa_pkg::csr_addr_t A_MEPC    = rv_isa_pkg::CSR_MEPC;
    localparam rv_isa_pkg::csr_addr_t A_MCAUSE  = rv_isa_pkg::CSR_MCAUSE;
    localparam rv_isa_pkg::csr_addr_t A_MIP     = rv_isa_pkg::CSR_MIP;
    localparam rv_isa_pkg::instr_t    ECALL     = 32'h0000_0073;
    localparam rv_isa_pkg::instr_t    MRET      = 32'h3020_0073;
    localparam rv_isa_pkg::xlen_t     PC0       = 64'h0000_0000_0000_1000;
    localparam rv_isa_pkg::xlen_t     ONES      = 64'hffff_ffff_ffff_ffff;

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid;
    rv_isa_pkg::instr_t    instr;
    rv_isa_pkg::xlen_t     pc;
    rv_isa_pkg::xlen_t     rs1_data;
    logic                  tcmp_we;
    rv_isa_pkg::xlen_t     tcmp_wdata;
    rv_isa_pkg::xlen_t     csr_rdata;
    logic                  redirect;
    rv_isa_pkg::xlen_t     redirect_pc;

    row_kind_e             kind_q[$];
    rv_isa_pkg::instr_t    instr_q[$];
    rv_isa_pkg::xlen_t     pc_q[$];
    rv_isa_pkg::xlen_t     rs1_q[$];
    rv_isa_pkg::xlen_t     rdata_q[$];
    logic                  redir_q[$];
    rv_isa_pkg::xlen_t     rpc_q[$];
    int                    n_rows = 0;
    int                    n_checks = 0;
    int                    n_errors = 0;

    csr_trap_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .pc_i           (pc),
        .csr_rs1_data_i (rs1_data),
        .tcmp_we_i      (tcmp_we),
        .tcmp_wdata_i   (tcmp_wdata),
        .csr_rdata_o    (csr_rdata),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic rv_isa_pkg::instr_t csr_instr(input logic [2:0] f3,
            input rv_isa_pkg::csr_addr_t addr, input logic [4:0] rs1);
        // rd is x1 throughout
        return {addr, rs1, f3, 5'd1, rv_isa_pkg::OPC_SYSTEM};
    endfunction

    function automatic rv_isa_pkg::instr_t rd_csr(input rv_isa_pkg::csr_addr_t addr);
        return csr_instr(rv_isa_pkg::F3_CSRRS, addr, 5'd0);
    endfunction

    task automatic add_row(input row_kind_e kind, input rv_isa_pkg::instr_t ins,
            input rv_isa_pkg::xlen_t row_pc, input rv_isa_pkg::xlen_t rs1,
            input rv_isa_pkg::xlen_t exp_rd, input logic exp_redir,
            input rv_isa_pkg::xlen_t exp_rpc);
        kind_q.push_back(kind);
        instr_q.push_back(ins);
        pc_q.push_back(row_pc);
        rs1_q.push_back(rs1);
        rdata_q.push_back(exp_rd);
        redir_q.push_back(exp_redir);
        rpc_q.push_back(exp_rpc);
    endtask

    task automatic add_instr(input rv_isa_pkg::instr_t ins, input rv_isa_pkg::xlen_t rs1,
            input rv_isa_pkg::xlen_t exp_rd);
        add_row(ROW_INSTR, ins, PC0, rs1, exp_rd, 1'b0, 64'h0);
    endtask

    task automatic add_redirect(input rv_isa_pkg::instr_t ins, input rv_isa_pkg::xlen_t row_pc,
            input rv_isa_pkg::xlen_t exp_rpc);
        add_row(ROW_INSTR, ins, row_pc, 64'h0, 64'h0, 1'b1, exp_rpc);
    endtask

    task automatic build_table();
        // reset values, unknown address and idle mip
        add_instr(rd_csr(A_MSTATUS), 64'h0, 64'h0000_000a_0000_1800);
        add_instr(rd_csr(A_MTVEC), 64'h0, 64'h0);
        add_instr(rd_csr(A_MEPC), 64'h0, 64'h0);
        add_instr(rd_csr(A_MCAUSE), 64'h0, 64'h0);
        add_instr(rd_csr(A_MIE), 64'h0, 64'h0);
        add_instr(rd_csr(12'h7c0), 64'h0, 64'h0);
        add_instr(rd_csr(A_MIP), 64'h0, 64'h0);
        // read-modify-write touches only the stored bits
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRW, A_MTVEC, 5'd5), 64'h8000_0103, 64'h0);
        add_instr(rd_csr(A_MTVEC), 64'h0, 64'h8000_0100);
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRS, A_MIE, 5'd5), ONES, 64'h0);
        add_instr(rd_csr(A_MIE), 64'h0, 64'h80);
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRC, A_MIE, 5'd5), 64'h80, 64'h80);
        add_instr(rd_csr(A_MIE), 64'h0, 64'h0);
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRWI, A_MSTATUS, 5'h1f), 64'h0,
                  64'h0000_000a_0000_1800);
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRCI, A_MSTATUS, 5'h08), 64'h0,
                  64'h0000_000a_0000_1808);
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRSI, A_MSTATUS, 5'h08), 64'h0,
                  64'h0000_000a_0000_1800);
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRSI, A_MSTATUS, 5'h00), 64'h0,
                  64'h0000_000a_0000_1808);
        // rs1 field zero means no write whatever the data
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRS, A_MIE, 5'd0), ONES, 64'h0);
        add_instr(rd_csr(A_MIE), 64'h0, 64'h0);
        add_instr(rd_csr(A_MSTATUS), 64'h0, 64'h0000_000a_0000_1808);
        // ecall then mret
        add_redirect(ECALL, 64'h2000_0040, 64'h8000_0100);
        add_instr(rd_csr(A_MEPC), 64'h0, 64'h2000_0040);
        add_instr(rd_csr(A_MCAUSE), 64'h0, 64'd11);
        add_instr(rd_csr(A_MSTATUS), 64'h0, 64'h0000_000a_0000_1880);
        add_redirect(MRET, PC0, 64'h2000_0040);
        add_instr(rd_csr(A_MSTATUS), 64'h0, 64'h0000_000a_0000_1888);
        // arm the timer so pending shows two rows later
        add_row(ROW_TCMP, 32'h0, PC0, 64'h0, 64'h0, 1'b0, 64'h0);
        add_row(ROW_IDLE, 32'h0, PC0, 64'h0, 64'h0, 1'b0, 64'h0);
        add_row(ROW_IDLE, 32'h0, PC0, 64'h0, 64'h0, 1'b0, 64'h0);
        add_instr(rd_csr(A_MIP), 64'h0, 64'h80);
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRCI, A_MSTATUS, 5'h08), 64'h0,
                  64'h0000_000a_0000_1888);
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRS, A_MIE, 5'd5), 64'h80, 64'h0);
        add_instr(rd_csr(A_MIP), 64'h0, 64'h80);
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRSI, A_MSTATUS, 5'h08), 64'h0,
                  64'h0000_000a_0000_1880);
        // interrupt replaces the csrrw so mtvec must stay
        add_row(ROW_INSTR, csr_instr(rv_isa_pkg::F3_CSRRW, A_MTVEC, 5'd5), 64'h3000_0014,
                64'hdead, 64'h0, 1'b1, 64'h8000_0100);
        add_instr(rd_csr(A_MTVEC), 64'h0, 64'h8000_0100);
        add_instr(rd_csr(A_MEPC), 64'h0, 64'h3000_0014);
        add_instr(rd_csr(A_MCAUSE), 64'h0, 64'h8000_0000_0000_0007);
        add_instr(rd_csr(A_MSTATUS), 64'h0, 64'h0000_000a_0000_1880);
        // disarm so mtip drops one row after the write lands
        add_row(ROW_TCMP, 32'h0, PC0, ONES, 64'h0, 1'b0, 64'h0);
        add_instr(rd_csr(A_MIP), 64'h0, 64'h80);
        add_instr(rd_csr(A_MIP), 64'h0, 64'h0);
        add_redirect(MRET, PC0, 64'h3000_0014);
        add_instr(rd_csr(A_MSTATUS), 64'h0, 64'h0000_000a_0000_1888);
        add_instr(rd_csr(A_MIP), 64'h0, 64'h0);
        // mret with mpie clear and mie set
        add_instr(csr_instr(rv_isa_pkg::F3_CSRRC, A_MSTATUS, 5'd5), 64'h80,
                  64'h0000_000a_0000_1888);
        add_redirect(MRET, PC0, 64'h3000_0014);
        add_instr(rd_csr(A_MSTATUS), 64'h0, 64'h0000_000a_0000_1880);
        add_row(ROW_IDLE, 32'h0, PC0, 64'h0, 64'h0, 1'b0, 64'h0);
    endtask

    task automatic check_xlen(input rv_isa_pkg::xlen_t got, input rv_isa_pkg::xlen_t exp,
            input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        rs1_data    = '0;
        tcmp_we     = 1'b0;
        tcmp_wdata  = '0;
        build_table();
        n_rows = kind_q.size();
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            #1;
            instr_valid = (kind_q[i] == ROW_INSTR);
            tcmp_we     = (kind_q[i] == ROW_TCMP);
            instr       = instr_q[i];
            pc          = pc_q[i];
            rs1_data    = rs1_q[i];
            tcmp_wdata  = rs1_q[i];
            // sample just before the next rising edge
            #7;
            check_xlen(csr_rdata, rdata_q[i], $sformatf("row %0d csr_rdata", i));
            check_bit(redirect, redir_q[i], $sformatf("row %0d redirect", i));
            if (redir_q[i]) begin
                check_xlen(redirect_pc, rpc_q[i], $sformatf("row %0d redirect_pc", i));
            end
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        tcmp_we     = 1'b0;
        $display("%0d rows, %0d checks, %0d errors", n_rows, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // table length plus 20 spare cycles
    initial begin
        wait (n_rows > 0);
        #((n_rows + 20) * 10);
        $display("timeout: the run did not finish within %0d cycles", n_rows + 20);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
